/* fetch_top.f */
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_resp_if.sv
rtl/pc_gen.sv
rtl/i_cache.sv
rtl/fetch_queue.sv
rtl/fetch_top.sv
verif/fetch_assertions.sv
verif/fetch_tb.sv

/* Makefile */
# Verilator build and run for the fetch front end.

VERILATOR ?= verilator
TOP       ?= fetch_tb
RTL_TOP   ?= fetch_top
FLIST     ?= fetch_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

PASS_TEXT := RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)

/* verif/fetch_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_tb;

    logic             clk;
    logic             rst;
    logic             redirect_valid;
    fetch_pkg::addr_t redirect_pc;
    logic             mem_req_valid;
    fetch_pkg::addr_t mem_req_addr;
    logic             mem_req_ready;
    fetch_pkg::inst_t mem_rd_data;
    logic             inst_valid;
    logic             inst_ready;
    fetch_pkg::addr_t inst_pc;
    fetch_pkg::inst_t inst_data;

    fetch_pkg::addr_t expected_pc;
    fetch_pkg::addr_t mem_log [$];
    int               since_redirect;
    int               mem_wait;
    logic             mem_busy;
    logic             random_ready;
    logic [31:0]      ready_state;
    logic [31:0]      mem_state;

    fetch_top UUT (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected memory contents, a scramble of the whole address.
    function automatic fetch_pkg::inst_t ref_inst(input fetch_pkg::addr_t addr);
        logic [31:0] x;
        x = addr * 32'h9e37_79b1;
        x = x ^ (x >> 15);
        return x ^ {addr[15:0], ~addr[15:0]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("Error: time %0t %s got %h expected %h", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic wait_delivered(input int n, input int limit);
        int cycles;
        cycles = 0;
        while (since_redirect < n)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > limit)
            begin
                $display("Timeout: only %0d of %0d instructions delivered", since_redirect, n);
                $display("RESULT: FAIL");
                $fatal(1, "delivery timeout");
            end
        end
    endtask

    task automatic pulse_redirect(input fetch_pkg::addr_t pc);
        @(posedge clk);
        redirect_valid <= 1'b1;
        redirect_pc    <= pc;
        @(posedge clk);
        redirect_valid <= 1'b0;
        @(posedge clk); // counter in the compare process is cleared by now.
    endtask

    function automatic int count_mem(input int from, input fetch_pkg::addr_t lo,
                                     input fetch_pkg::addr_t hi);
        int n;
        n = 0;
        for (int i = from; i < mem_log.size(); i++)
        begin
            if (mem_log[i] >= lo && mem_log[i] <= hi)
            begin
                n++;
            end
        end
        return n;
    endfunction

    // memory model, 0 to 3 cycles before ready.
    always @(posedge clk)
    begin
        if (rst)
        begin
            mem_req_ready <= 1'b0;
            mem_busy = 1'b0;
        end
        else if (mem_req_ready)
        begin
            mem_log.push_back(mem_req_addr);
            mem_req_ready <= 1'b0;
            mem_busy = 1'b0;
        end
        else if (mem_req_valid)
        begin
            if (!mem_busy)
            begin
                mem_busy  = 1'b1;
                mem_state = lcg_next(mem_state);
                mem_wait  = int'(mem_state[17:16]);
            end
            if (mem_wait == 0)
            begin
                mem_req_ready <= 1'b1;
                mem_rd_data   <= ref_inst(mem_req_addr);
            end
            else
            begin
                mem_wait--;
            end
        end
    end

    always @(posedge clk)
    begin
        if (random_ready)
        begin
            ready_state = lcg_next(ready_state);
            inst_ready <= ready_state[16];
        end
        else
        begin
            inst_ready <= 1'b1;
        end
    end

    // compare process, transfer first and then the redirect of the same edge.
    always @(posedge clk)
    begin
        if (rst)
        begin
            expected_pc    = fetch_pkg::addr_t'(`FETCH_RESET_PC);
            since_redirect = 0;
        end
        else
        begin
            if (inst_valid && inst_ready)
            begin
                check_value("inst_pc", inst_pc, expected_pc);
                check_value("inst_data", inst_data, ref_inst(expected_pc));
                expected_pc = expected_pc + 32'd1;
                since_redirect++;
            end
            if (redirect_valid)
            begin
                expected_pc    = redirect_pc;
                since_redirect = 0;
            end
        end
    end

    initial
    begin
        int snap;
        clk            = 1'b0;
        rst            = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        mem_req_ready  = 1'b0;
        mem_rd_data    = '0;
        inst_ready     = 1'b0;
        random_ready   = 1'b0;
        ready_state    = 32'h344d;
        mem_state      = 32'h344d ^ 32'h5a5a_0000;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        wait_delivered(16, 2000); // words 0 to 15, all misses.

        // overrun prefetch may evict the low lines, so only 8..15 must hit.
        snap = mem_log.size();
        pulse_redirect(32'h0);
        wait_delivered(16, 2000);
        check_value("hit pass memory requests", count_mem(snap, 32'h8, 32'hf), 0);

        // same index as word 8, other tag.
        snap = mem_log.size();
        pulse_redirect(32'h108);
        wait_delivered(1, 500);
        check_value("conflict memory requests", count_mem(snap, 32'h108, 32'h108), 1);

        random_ready = 1'b1;
        pulse_redirect(32'h200);
        wait_delivered(40, 4000);
        pulse_redirect(32'h37c);
        wait_delivered(30, 4000);
        pulse_redirect(32'h5);
        wait_delivered(20, 4000);

        if (UUT.u_i_cache.u_fetch_assertions.failures == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/fetch_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_assertions (
    input wire                          clk,
    input wire                          rst,
    input wire                          redirect_valid,
    input wire fetch_pkg::addr_t        req_addr,
    input wire                          hit,
    input wire                          mem_req_valid,
    input wire fetch_pkg::addr_t        mem_req_addr,
    input wire                          mem_req_ready,
    input wire                          resp_valid,
    input wire                          resp_free,
    input wire fetch_pkg::addr_t        resp_pc,
    input wire fetch_pkg::inst_t        resp_data,
    input wire fetch_pkg::cache_state_e state
);

    int failures = 0; // failed assertions so far.

    // memory request held with its address until accepted.
    mem_req_held: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr))
        else
        begin
            failures++;
            $error("memory request dropped or address changed before ready");
        end

    // a redirect may drop the response, nothing else may.
    resp_held: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_free && !redirect_valid
            |=> resp_valid && $stable(resp_pc) && $stable(resp_data))
        else
        begin
            failures++;
            $error("cache response dropped or payload changed before ready");
        end

    // the refilled line serves the held request on the next lookup.
    refill_hit: assert property (@(posedge clk) disable iff (rst)
        state == fetch_pkg::REFILL && mem_req_ready && !redirect_valid
            && req_addr == mem_req_addr
            |=> state == fetch_pkg::LOOKUP && hit)
        else
        begin
            failures++;
            $error("held request missed right after its refill");
        end

endmodule

bind i_cache fetch_assertions u_fetch_assertions (
    .clk            (clk),
    .rst            (rst),
    .redirect_valid (redirect_valid),
    .req_addr       (req_addr),
    .hit            (hit),
    .mem_req_valid  (mem_req_valid),
    .mem_req_addr   (mem_req_addr),
    .mem_req_ready  (mem_req_ready),
    .resp_valid     (resp_valid_q),
    .resp_free      (out_free), // equals ready while the register is full.
    .resp_pc        (resp_pc_q),
    .resp_data      (resp_data_q),
    .state          (state)
);

`default_nettype wire

/* rtl/fetch_top.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_top (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   redirect_valid,
    input  wire fetch_pkg::addr_t redirect_pc,
    output logic                  mem_req_valid,
    output fetch_pkg::addr_t      mem_req_addr,
    input  wire                   mem_req_ready,
    input  wire fetch_pkg::inst_t mem_rd_data,
    output logic                  inst_valid,
    input  wire                   inst_ready,
    output fetch_pkg::addr_t      inst_pc,
    output fetch_pkg::inst_t      inst_data
);

    logic             req_valid;
    logic             req_ready;
    fetch_pkg::addr_t req_addr;

    fetch_resp_if resp_if ();

    pc_gen u_pc_gen (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .req_ready      (req_ready),
        .req_valid      (req_valid),
        .req_addr       (req_addr)
    );

    i_cache u_i_cache (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .req_valid      (req_valid),
        .req_addr       (req_addr),
        .req_ready      (req_ready),
        .resp           (resp_if.source),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_ready  (mem_req_ready),
        .mem_rd_data    (mem_rd_data)
    );

    fetch_queue u_fetch_queue (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .resp           (resp_if.sink),
        .inst_valid     (inst_valid),
        .inst_pc        (inst_pc),
        .inst_data      (inst_data),
        .inst_ready     (inst_ready)
    );

endmodule

`default_nettype wire

/* rtl/fetch_queue.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_queue (
    input  wire               clk,
    input  wire               rst,
    input  wire               redirect_valid,
    fetch_resp_if.sink        resp,
    output logic              inst_valid,
    output fetch_pkg::addr_t  inst_pc,
    output fetch_pkg::inst_t  inst_data,
    input  wire               inst_ready
);

    localparam int DEPTH = `FETCH_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_pkg::addr_t pc_mem   [DEPTH];
    fetch_pkg::inst_t data_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign resp.ready = (count != CNT_W'(DEPTH)); // low when full.
    assign inst_valid = (count != '0);

    assign push = resp.valid && resp.ready;
    assign pop  = inst_valid && inst_ready;

    always_ff @(posedge clk)
    begin
        if (rst || redirect_valid)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop)
            begin
                count <= count + 1'b1;
            end
            else if (pop && !push)
            begin
                count <= count - 1'b1;
            end
        end
    end

    // storage.
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            pc_mem[wr_ptr]   <= resp.pc;
            data_mem[wr_ptr] <= resp.data;
        end
    end

    assign inst_pc   = pc_mem[rd_ptr];
    assign inst_data = data_mem[rd_ptr];

endmodule

`default_nettype wire

/* rtl/i_cache.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_consts.svh"

module i_cache (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   redirect_valid,
    input  wire                   req_valid,
    input  wire fetch_pkg::addr_t req_addr,
    output logic                  req_ready,
    fetch_resp_if.source          resp,
    output logic                  mem_req_valid,
    output fetch_pkg::addr_t      mem_req_addr,
    input  wire                   mem_req_ready,
    input  wire fetch_pkg::inst_t mem_rd_data
);

    fetch_pkg::cache_line_t  lines [`FETCH_LINES];
    fetch_pkg::cache_state_e state;

    logic [`FETCH_INDEX_BITS-1:0] req_index;
    logic [`FETCH_TAG_BITS-1:0]   req_tag;
    logic [`FETCH_INDEX_BITS-1:0] fill_index;
    logic [`FETCH_TAG_BITS-1:0]   fill_tag;
    fetch_pkg::cache_line_t       lookup_line;

    logic hit;
    logic out_free;
    logic accept;
    logic miss;
    logic fill;

    // output register.
    logic             resp_valid_q;
    fetch_pkg::addr_t resp_pc_q;
    fetch_pkg::inst_t resp_data_q;

    assign req_index   = req_addr[`FETCH_INDEX_BITS-1:0];
    assign req_tag     = req_addr[`FETCH_INDEX_BITS +: `FETCH_TAG_BITS];
    assign lookup_line = lines[req_index];
    assign hit         = lookup_line.valid && (lookup_line.tag == req_tag);

    // free when empty or being drained this cycle.
    assign out_free = !resp_valid_q || resp.ready;

    assign req_ready = (state == fetch_pkg::LOOKUP) && hit && out_free && !redirect_valid;
    assign accept    = req_valid && req_ready;

    // a miss only starts a refill when no redirect is replacing the pc.
    assign miss = req_valid && (state == fetch_pkg::LOOKUP) && !hit && !redirect_valid;

    assign mem_req_valid = (state == fetch_pkg::REFILL);
    assign fill          = mem_req_valid && mem_req_ready;
    assign fill_index    = mem_req_addr[`FETCH_INDEX_BITS-1:0];
    assign fill_tag      = mem_req_addr[`FETCH_INDEX_BITS +: `FETCH_TAG_BITS];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= fetch_pkg::LOOKUP;
        end
        else
        begin
            case (state)
                fetch_pkg::LOOKUP:
                begin
                    if (miss)
                    begin
                        state <= fetch_pkg::REFILL;
                    end
                end
                fetch_pkg::REFILL:
                begin
                    // an open transaction always completes, even after a redirect.
                    if (mem_req_ready)
                    begin
                        state <= fetch_pkg::LOOKUP;
                    end
                end
            endcase
        end
    end

    // miss address, held for the whole refill.
    always_ff @(posedge clk)
    begin
        if (miss)
        begin
            mem_req_addr <= req_addr;
        end
    end

    // line array, only the valid bits are cleared.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `FETCH_LINES; i++)
            begin
                lines[i].valid <= 1'b0;
            end
        end
        else if (fill)
        begin
            lines[fill_index] <= '{valid: 1'b1, tag: fill_tag, data: mem_rd_data};
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            resp_valid_q <= 1'b0;
        end
        else if (redirect_valid)
        begin
            resp_valid_q <= 1'b0; // drop stale response.
        end
        else if (accept)
        begin
            resp_valid_q <= 1'b1;
        end
        else if (resp.ready)
        begin
            resp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            resp_pc_q   <= req_addr;
            resp_data_q <= lookup_line.data;
        end
    end

    assign resp.valid = resp_valid_q;
    assign resp.pc    = resp_pc_q;
    assign resp.data  = resp_data_q;

endmodule

`default_nettype wire

/* rtl/pc_gen.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_consts.svh"

module pc_gen (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   redirect_valid,
    input  wire fetch_pkg::addr_t redirect_pc,
    input  wire                   req_ready,
    output logic                  req_valid,
    output fetch_pkg::addr_t      req_addr
);

    fetch_pkg::addr_t fetch_ptr;
    logic             running;
    logic             advance;

    assign advance = req_valid && req_ready;

    // comes up one cycle after reset and stays up.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            running <= 1'b0;
        end
        else
        begin
            running <= 1'b1;
        end
    end

    // redirect wins over a transfer in the same cycle.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            fetch_ptr <= fetch_pkg::addr_t'(`FETCH_RESET_PC);
        end
        else if (redirect_valid)
        begin
            fetch_ptr <= redirect_pc;
        end
        else if (advance)
        begin
            fetch_ptr <= fetch_ptr + fetch_pkg::addr_t'(1); // next word.
        end
    end

    assign req_valid = running;
    assign req_addr  = fetch_ptr; // held until accepted.

endmodule

`default_nettype wire

/* rtl/fetch_resp_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface fetch_resp_if;

    logic             valid;
    logic             ready;
    fetch_pkg::addr_t pc;
    fetch_pkg::inst_t data;

    // cache side.
    modport source (
        output valid,
        output pc,
        output data,
        input  ready
    );

    // queue side.
    modport sink (
        input  valid,
        input  pc,
        input  data,
        output ready
    );

endinterface

`default_nettype wire

/* rtl/fetch_pkg.sv */
`default_nettype none

`include "fetch_consts.svh"

package fetch_pkg;

    // word address and instruction word.
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    // one cache line, 1 + 12 + 32 bits.
    typedef struct packed {
        logic                       valid;
        logic [`FETCH_TAG_BITS-1:0] tag;
        inst_t                      data;
    } cache_line_t;

    typedef enum logic {
        LOOKUP = 1'b0,
        REFILL = 1'b1 // waiting on memory.
    } cache_state_e;

endpackage

`default_nettype wire

/* rtl/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// cache geometry, index from addr[3:0] and tag from addr[15:4].
`define FETCH_INDEX_BITS 4
`define FETCH_TAG_BITS 12
`define FETCH_LINES 16

// output queue.
`define FETCH_QUEUE_DEPTH 4

// first word fetched after reset.
`define FETCH_RESET_PC 32'h0000_0000

`endif
